/* verilog/spi_bridge_pkg.sv */
package spi_bridge_pkg;

    // ******************************
    // SPI frame format and timing
    // ******************************

    localparam int SPI_WORD_BITS = 16;

    // One SCLK period is split into setup, rise, hold and fall phases.
    localparam int SPI_BIT_CLKS = 4;

    // Clocks with CS high after the tail before done is raised.
    localparam int SPI_GUARD_CLKS = 10;

    // CS fall, the bits, three tail clocks, CS rise and the guard time.
    localparam int SPI_FRAME_CLKS = 1 + SPI_WORD_BITS * SPI_BIT_CLKS + 3 + 1 + SPI_GUARD_CLKS;

    localparam int CMD_QUEUE_DEPTH = 4;

    // Upper byte of every reply from the peripheral.
    localparam logic [7:0] CHIP_STATUS = 8'h5A;

    // ******************************
    // SPI word
    // ******************************

    // The same word seen as the serial stream (MSB first) and as command fields.
    // In a read reply the rw and addr fields carry the status byte.
    typedef union packed {
        logic [SPI_WORD_BITS-1:0] raw;
        struct packed {
            logic       rw;
            logic [6:0] addr;
            logic [7:0] data;
        } cmd;
    } spi_word_u;

endpackage

/* verilog/cmd_queue.sv */
`timescale 1ns/10ps

module cmd_queue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  spi_bridge_pkg::spi_word_u push_word,
    input  logic                      pop,
    output spi_bridge_pkg::spi_word_u head_word,
    output logic                      empty,
    output logic                      overflow
);
    import spi_bridge_pkg::*;

    spi_word_u mem [CMD_QUEUE_DEPTH];

    logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(CMD_QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(CMD_QUEUE_DEPTH+1)-1:0] count;
    logic                                 full;
    logic                                 do_push;
    logic                                 do_pop;

    assign full    = (int'(count) == CMD_QUEUE_DEPTH);
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_word = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_word;
        end
    end

    // The depth is a power of two, so both pointers wrap by themselves.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && full;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/spi_word_master.sv */
`timescale 1ns/10ps

module spi_word_master (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  spi_bridge_pkg::spi_word_u tx_word,
    output logic                      busy,
    output logic                      done,
    output spi_bridge_pkg::spi_word_u rx_lead,
    output spi_bridge_pkg::spi_word_u rx_trail,
    output logic                      sclk,
    output logic                      mosi,
    output logic                      cs_n,
    input  logic                      miso
);
    import spi_bridge_pkg::*;

    logic       launch;
    logic       cs_clk;
    logic       bit_run;
    logic       tail_run;
    logic       guard_run;
    logic [1:0] phase;
    logic [3:0] bit_cnt;
    logic [1:0] tail_cnt;
    logic [3:0] guard_cnt;

    logic ph_setup;
    logic ph_rise;
    logic ph_hold;
    logic ph_fall;
    logic last_bit;
    logic tail_trail;
    logic tail_end;

    spi_word_u tx_sh;
    spi_word_u lead_sh;
    spi_word_u trail_sh;

    assign launch = start && !busy;

    assign ph_setup = bit_run && (phase == 2'd0);
    assign ph_rise  = bit_run && (phase == 2'd1);
    assign ph_hold  = bit_run && (phase == 2'd2);
    assign ph_fall  = bit_run && (phase == 2'(SPI_BIT_CLKS - 1));
    assign last_bit = (bit_cnt == 4'(SPI_WORD_BITS - 1));

    // Tail clocks are numbered 1 to 3.
    assign tail_trail = tail_run && (tail_cnt == 2'd2);
    assign tail_end   = tail_run && (tail_cnt == 2'd3);

    // ******************************
    // Frame sequencing and pins
    // ******************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            done      <= 1'b0;
            cs_clk    <= 1'b0;
            bit_run   <= 1'b0;
            tail_run  <= 1'b0;
            guard_run <= 1'b0;
            phase     <= '0;
            bit_cnt   <= '0;
            tail_cnt  <= '0;
            guard_cnt <= '0;
            sclk      <= 1'b0;
            mosi      <= 1'b0;
            cs_n      <= 1'b1;
        end else begin
            done   <= 1'b0;
            cs_clk <= 1'b0;

            if (launch) begin
                busy   <= 1'b1;
                cs_clk <= 1'b1;
                cs_n   <= 1'b0;
            end

            // One clock with CS low before the first bit.
            if (cs_clk) begin
                bit_run <= 1'b1;
                phase   <= '0;
                bit_cnt <= '0;
            end

            if (bit_run) begin
                phase <= phase + 1'b1;
                if (ph_setup) begin
                    mosi <= tx_sh.raw[SPI_WORD_BITS-1];
                end
                if (ph_rise) begin
                    sclk <= 1'b1;
                end
                if (ph_fall) begin
                    sclk <= 1'b0;
                    if (last_bit) begin
                        bit_run  <= 1'b0;
                        tail_run <= 1'b1;
                        tail_cnt <= 2'd1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end

            if (tail_run) begin
                tail_cnt <= tail_cnt + 1'b1;
                if (tail_end) begin
                    tail_run  <= 1'b0;
                    cs_n      <= 1'b1;
                    mosi      <= 1'b0;
                    guard_run <= 1'b1;
                    guard_cnt <= '0;
                end
            end

            // done lands right after the last guard clock, with busy already low.
            if (guard_run) begin
                guard_cnt <= guard_cnt + 1'b1;
                if (guard_cnt == 4'(SPI_GUARD_CLKS - 1)) begin
                    guard_run <= 1'b0;
                    busy      <= 1'b0;
                    done      <= 1'b1;
                end
            end
        end
    end

    // ******************************
    // Shift registers
    // ******************************

    // The lead point samples while SCLK is high. The trail point samples half a
    // bit later, after the fall, and for the last bit in the second tail clock.
    always_ff @(posedge clk) begin
        if (launch) begin
            tx_sh <= tx_word;
        end else if (ph_fall) begin
            tx_sh.raw <= {tx_sh.raw[SPI_WORD_BITS-2:0], 1'b0};
        end

        if (ph_hold) begin
            lead_sh.raw <= {lead_sh.raw[SPI_WORD_BITS-2:0], miso};
        end

        if ((ph_setup && bit_cnt != 4'd0) || tail_trail) begin
            trail_sh.raw <= {trail_sh.raw[SPI_WORD_BITS-2:0], miso};
        end

        if (tail_end) begin
            rx_lead  <= lead_sh;
            rx_trail <= trail_sh;
        end
    end

endmodule

/* verilog/spi_cmd_sequencer.sv */
`timescale 1ns/10ps

module spi_cmd_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      q_empty,
    input  spi_bridge_pkg::spi_word_u q_word,
    output logic                      q_pop,
    input  logic                      trail_capture,
    output logic                      start,
    output spi_bridge_pkg::spi_word_u tx_word,
    input  logic                      busy,
    input  logic                      done,
    input  spi_bridge_pkg::spi_word_u rx_lead,
    input  spi_bridge_pkg::spi_word_u rx_trail,
    output logic                      rsp_valid,
    output logic [6:0]                rsp_addr,
    output logic [7:0]                rsp_status,
    output logic [7:0]                rsp_data
);
    import spi_bridge_pkg::*;

    logic      launch;
    logic      rd_pend;
    logic      rsp_take;
    logic [6:0] cur_addr;
    spi_word_u reply;

    // ******************************
    // Command issue
    // ******************************

    // The head word goes out in the same cycle it leaves the queue. The master
    // drops busy in its done cycle, so back-to-back frames have no gap.
    assign launch  = !q_empty && !busy;
    assign q_pop   = launch;
    assign start   = launch;
    assign tx_word = q_word;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else if (launch) begin
            rd_pend <= q_word.cmd.rw;
        end else if (done) begin
            rd_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            cur_addr <= q_word.cmd.addr;
        end
    end

    // ******************************
    // Read results
    // ******************************

    assign reply    = trail_capture ? rx_trail : rx_lead;
    assign rsp_take = done && rd_pend;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_take;
        end
    end

    // Status sits where the command had rw and addr; data keeps its place.
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            rsp_addr   <= cur_addr;
            rsp_status <= {reply.cmd.rw, reply.cmd.addr};
            rsp_data   <= reply.cmd.data;
        end
    end

endmodule

/* verilog/spi_bridge_top.sv */
`timescale 1ns/10ps

module spi_bridge_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cmd_push,
    input  spi_bridge_pkg::spi_word_u cmd_word,
    output logic                      cmd_overflow,
    input  logic                      trail_capture,
    output logic                      rsp_valid,
    output logic [6:0]                rsp_addr,
    output logic [7:0]                rsp_status,
    output logic [7:0]                rsp_data,
    output logic                      sclk,
    output logic                      mosi,
    output logic                      cs_n,
    input  logic                      miso
);
    import spi_bridge_pkg::*;

    spi_word_u q_word;
    spi_word_u tx_word;
    spi_word_u rx_lead;
    spi_word_u rx_trail;
    logic      q_empty;
    logic      q_pop;
    logic      start;
    logic      busy;
    logic      done;

    cmd_queue cmd_queue_i (
        .clk       (clk),
        .rst       (rst),
        .push      (cmd_push),
        .push_word (cmd_word),
        .pop       (q_pop),
        .head_word (q_word),
        .empty     (q_empty),
        .overflow  (cmd_overflow)
    );

    spi_cmd_sequencer spi_cmd_sequencer_i (
        .clk           (clk),
        .rst           (rst),
        .q_empty       (q_empty),
        .q_word        (q_word),
        .q_pop         (q_pop),
        .trail_capture (trail_capture),
        .start         (start),
        .tx_word       (tx_word),
        .busy          (busy),
        .done          (done),
        .rx_lead       (rx_lead),
        .rx_trail      (rx_trail),
        .rsp_valid     (rsp_valid),
        .rsp_addr      (rsp_addr),
        .rsp_status    (rsp_status),
        .rsp_data      (rsp_data)
    );

    spi_word_master spi_word_master_i (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .tx_word  (tx_word),
        .busy     (busy),
        .done     (done),
        .rx_lead  (rx_lead),
        .rx_trail (rx_trail),
        .sclk     (sclk),
        .mosi     (mosi),
        .cs_n     (cs_n),
        .miso     (miso)
    );

endmodule

/* verification/spi_chip_model.sv */
`timescale 1ns/10ps

module spi_chip_model (
    input  logic late,
    input  logic sclk,
    input  logic mosi,
    input  logic cs_n,
    output logic miso
);
    import spi_bridge_pkg::*;

    logic [7:0]  regs [128];
    logic [15:0] rx_sh;
    logic [7:0]  rd_byte;
    int          rx_cnt;

    // Reply bit idx, counted from the MSB of the status byte.
    function automatic logic reply_bit(input int idx);
        if (idx < 8) begin
            return CHIP_STATUS[7-idx];
        end
        return rd_byte[15-idx];
    endfunction

    initial begin
        int n;
        miso    = 1'b0;
        rx_cnt  = 0;
        rx_sh   = '0;
        rd_byte = '0;
        for (n = 0; n < 128; n++) begin
            regs[n] = 8'(n) ^ 8'hC3;
        end
    end

    always @(negedge cs_n) begin
        rx_cnt = 0;
        if (!late) begin
            miso <= reply_bit(0);
        end
    end

    // The register is looked up as soon as the command byte is complete.
    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_sh = {rx_sh[14:0], mosi};
            rx_cnt++;
            if (rx_cnt == 8) begin
                rd_byte = regs[rx_sh[6:0]];
            end
            // A slow chip only gets its bit out at the rise.
            if (late) begin
                miso <= reply_bit(rx_cnt - 1);
            end
        end
    end

    always @(negedge sclk) begin
        if (!cs_n && !late && rx_cnt < SPI_WORD_BITS) begin
            miso <= reply_bit(rx_cnt);
        end
    end

    always @(posedge cs_n) begin
        if (rx_cnt == SPI_WORD_BITS && !rx_sh[15]) begin
            regs[rx_sh[14:8]] = rx_sh[7:0];
        end
        miso <= 1'b0;
    end

endmodule

/* verification/tb_spi_bridge.sv */
`timescale 1ns/10ps

module tb_spi_bridge;
    import spi_bridge_pkg::*;

    logic       clk;
    logic       rst;
    logic       cmd_push;
    spi_word_u  cmd_word;
    logic       cmd_overflow;
    logic       trail_capture;
    logic       rsp_valid;
    logic [6:0] rsp_addr;
    logic [7:0] rsp_status;
    logic [7:0] rsp_data;
    logic       sclk;
    logic       mosi;
    logic       cs_n;
    logic       miso;
    logic       late;

    int         seed;
    logic [7:0] shadow [128];
    logic [6:0] exp_addr [$];
    spi_word_u  exp_reply [$];
    int         fall_cycles [$];
    int         frames_issued = 0;
    int         frames_done = 0;
    int         cycle_cnt = 0;
    int         sclk_rises = 0;
    int         ovf_count = 0;
    int         cs_low_cnt = 0;
    int         frame_rises = 0;
    logic       cs_prev = 1'b1;
    logic       sclk_prev = 1'b0;

    spi_bridge_top spi_bridge_top_i (
        .clk (clk), .rst (rst), .cmd_push (cmd_push), .cmd_word (cmd_word),
        .cmd_overflow (cmd_overflow), .trail_capture (trail_capture),
        .rsp_valid (rsp_valid), .rsp_addr (rsp_addr), .rsp_status (rsp_status),
        .rsp_data (rsp_data), .sclk (sclk), .mosi (mosi), .cs_n (cs_n), .miso (miso)
    );

    spi_chip_model spi_chip_model_i (
        .late (late), .sclk (sclk), .mosi (mosi), .cs_n (cs_n), .miso (miso)
    );

    always #2 clk = ~clk;

    // ******************************
    // Checking helpers
    // ******************************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_reply(input spi_word_u got, input spi_word_u exp);
        if (got.raw !== exp.raw) begin
            fail_run($sformatf("CHECK FAILED at %0t: rsp_status/rsp_data got %h expected %h",
                               $time, got.raw, exp.raw));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                               $time, name, got, exp));
        end
    endtask

    function automatic spi_word_u make_cmd(input logic rw, input logic [6:0] addr,
                                           input logic [7:0] data);
        spi_word_u w;
        w.cmd.rw   = rw;
        w.cmd.addr = addr;
        w.cmd.data = data;
        return w;
    endfunction

    // The chip answers a read with its status byte and the current register.
    function automatic spi_word_u ref_reply(input logic [6:0] addr);
        spi_word_u w;
        w.raw = {CHIP_STATUS, shadow[addr]};
        return w;
    endfunction

    task automatic push_cmd(input spi_word_u w, input bit dropped);
        spi_word_u exp_word;
        cmd_push = 1'b1;
        cmd_word = w;
        if (!dropped) begin
            frames_issued++;
            if (w.cmd.rw) begin
                exp_word = ref_reply(w.cmd.addr);
                // A fast chip has moved on to the next bit when the trail point samples.
                // Nothing follows the last bit, so it is taken twice.
                if (trail_capture && !late) begin
                    exp_word.raw = {exp_word.raw[SPI_WORD_BITS-2:0], exp_word.raw[0]};
                end
                exp_addr.push_back(w.cmd.addr);
                exp_reply.push_back(exp_word);
            end else begin
                shadow[w.cmd.addr] = w.cmd.data;
            end
        end
        @(posedge clk);
        #1;
        cmd_push = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 8 * SPI_FRAME_CLKS) begin
                fail_run("Timeout: the bridge did not finish its queued commands.");
            end
        end while (frames_done != frames_issued || exp_addr.size() != 0);
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
            if (n > 2 * SPI_FRAME_CLKS) begin
                fail_run("Timeout: no frame started after a command was pushed.");
            end
        end while (cs_n);
    endtask

    // ******************************
    // Monitors
    // ******************************

    always @(posedge clk) begin
        cycle_cnt++;
        if (cmd_overflow) begin
            ovf_count++;
        end
        if (!cs_n) begin
            if (cs_prev) begin
                fall_cycles.push_back(cycle_cnt);
            end
            cs_low_cnt++;
            if (sclk && !sclk_prev) begin
                frame_rises++;
            end
        end else if (!cs_prev) begin
            check_count("cs_n low cycles", cs_low_cnt, SPI_FRAME_CLKS - SPI_GUARD_CLKS - 1);
            check_count("sclk rises in frame", frame_rises, SPI_WORD_BITS);
            frames_done++;
            cs_low_cnt  = 0;
            frame_rises = 0;
        end
        if (sclk && !sclk_prev) begin
            sclk_rises++;
        end
        cs_prev   = cs_n;
        sclk_prev = sclk;
    end

    always @(posedge clk) begin : compare_results
        spi_word_u got;
        if (!rst && rsp_valid) begin
            if (exp_addr.size() == 0) begin
                fail_run("A read result appeared with no read outstanding.");
            end
            got.raw = {rsp_status, rsp_data};
            check_byte("rsp_addr", {1'b0, rsp_addr}, {1'b0, exp_addr.pop_front()});
            check_reply(got, exp_reply.pop_front());
        end
    end

    // ******************************
    // Stimulus
    // ******************************

    initial begin
        int         i;
        int         n0;
        logic [6:0] a0;
        logic [6:0] a1;
        logic [7:0] d0;
        logic [7:0] d1;
        clk           = 1'b0;
        rst           = 1'b1;
        cmd_push      = 1'b0;
        cmd_word      = '0;
        trail_capture = 1'b0;
        late          = 1'b0;
        seed          = 28;
        for (i = 0; i < 128; i++) begin
            shadow[i] = 8'(i) ^ 8'hC3;
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        check_bit("cs_n", cs_n, 1'b1);
        check_bit("sclk", sclk, 1'b0);
        check_bit("mosi", mosi, 1'b0);
        check_bit("rsp_valid", rsp_valid, 1'b0);
        n0 = sclk_rises;
        repeat (200) @(posedge clk);
        #1;
        check_count("sclk rises while idle", sclk_rises - n0, 0);

        // Reset contents with lead capture.
        push_cmd(make_cmd(1'b1, 7'h00, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h2A, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h55, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h7F, 8'h00), 1'b0);
        wait_idle();

        // The trail point on a fast chip sees every bit one place early.
        trail_capture = 1'b1;
        push_cmd(make_cmd(1'b1, 7'h2A, 8'h00), 1'b0);
        wait_idle();
        trail_capture = 1'b0;

        repeat (4) begin
            a0 = 7'($random(seed));
            a1 = 7'($random(seed));
            d0 = 8'($random(seed));
            d1 = 8'($random(seed));
            push_cmd(make_cmd(1'b0, a0, d0), 1'b0);
            push_cmd(make_cmd(1'b0, a1, d1), 1'b0);
            push_cmd(make_cmd(1'b1, a0, 8'h00), 1'b0);
            push_cmd(make_cmd(1'b1, a1, 8'h00), 1'b0);
            wait_idle();
        end

        // A slow chip changes its bit at the rise and is read at the trail point.
        late          = 1'b1;
        trail_capture = 1'b1;
        repeat (3) begin
            a0 = 7'($random(seed));
            a1 = 7'($random(seed));
            d0 = 8'($random(seed));
            push_cmd(make_cmd(1'b0, a0, d0), 1'b0);
            push_cmd(make_cmd(1'b1, a0, 8'h00), 1'b0);
            push_cmd(make_cmd(1'b1, a1, 8'h00), 1'b0);
            push_cmd(make_cmd(1'b1, 7'h13, 8'h00), 1'b0);
            wait_idle();
        end
        late          = 1'b0;
        trail_capture = 1'b0;

        // Fill the queue behind a running frame; the fifth push is lost.
        fall_cycles.delete();
        n0 = ovf_count;
        push_cmd(make_cmd(1'b0, 7'h20, 8'($random(seed))), 1'b0);
        wait_frame_start();
        push_cmd(make_cmd(1'b1, 7'h21, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b0, 7'h22, 8'($random(seed))), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h22, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h23, 8'h00), 1'b0);
        push_cmd(make_cmd(1'b1, 7'h24, 8'h00), 1'b1);
        wait_idle();
        check_count("cmd_overflow pulses", ovf_count - n0, 1);
        check_count("frames after overflow", fall_cycles.size(), 5);
        for (i = 1; i < fall_cycles.size(); i++) begin
            check_count("cs_n fall spacing", fall_cycles[i] - fall_cycles[i-1], SPI_FRAME_CLKS);
        end
        repeat (2 * SPI_FRAME_CLKS) @(posedge clk);

        $display("TEST OK");
        $finish;
    end

endmodule

/* files.f */
verilog/spi_bridge_pkg.sv
verilog/cmd_queue.sv
verilog/spi_word_master.sv
verilog/spi_cmd_sequencer.sv
verilog/spi_bridge_top.sv
verification/spi_chip_model.sv
verification/tb_spi_bridge.sv
